// File: common/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [6:0]  md_op_t;
    typedef logic [7:0]  mem_op_t;
    typedef logic [1:0]  cnt_op_t;
    typedef logic [5:0]  exc_in_t;
    typedef logic [6:0]  exc_t;      // {ale, exc_in_t}
    typedef logic [63:0] stable_cnt_t;

    // alu_op_t bit positions
    localparam int op_add  = 0;
    localparam int op_sub  = 1;
    localparam int op_slt  = 2;
    localparam int op_sltu = 3;
    localparam int op_and  = 4;
    localparam int op_nor  = 5;
    localparam int op_or   = 6;
    localparam int op_xor  = 7;
    localparam int op_sll  = 8;
    localparam int op_srl  = 9;
    localparam int op_sra  = 10;
    localparam int op_lui  = 11;

    // md_op_t bit positions, all zero means alu
    localparam int md_mul_w   = 0;
    localparam int md_mulh_w  = 1;
    localparam int md_mulh_wu = 2;
    localparam int md_div_w   = 3;
    localparam int md_mod_w   = 4;
    localparam int md_div_wu  = 5;
    localparam int md_mod_wu  = 6;

    // mem_op_t bit positions
    localparam int mem_ld_w  = 0;
    localparam int mem_ld_h  = 1;
    localparam int mem_ld_hu = 2;
    localparam int mem_ld_b  = 3;
    localparam int mem_ld_bu = 4;
    localparam int mem_st_w  = 5;
    localparam int mem_st_h  = 6;
    localparam int mem_st_b  = 7;

    localparam int cnt_vl = 0;
    localparam int cnt_vh = 1;

endpackage

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
    input  wire ex_pkg::alu_op_t alu_op,
    input  wire ex_pkg::word_t   alu_src1,
    input  wire ex_pkg::word_t   alu_src2,
    output ex_pkg::word_t        alu_result
);

    logic          use_sub;
    ex_pkg::word_t adder_b;
    logic [32:0]   adder_sum;
    logic          slt_res;
    logic          sltu_res;
    ex_pkg::word_t sll_res;
    ex_pkg::word_t srl_res;
    ex_pkg::word_t sra_res;

    // one adder serves add, sub and both compares
    assign use_sub = alu_op[ex_pkg::op_sub] | alu_op[ex_pkg::op_slt] | alu_op[ex_pkg::op_sltu];
    assign adder_b = use_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, use_sub};

    assign slt_res = (alu_src1[31] & ~alu_src2[31])
                   | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31]);
    assign sltu_res = ~adder_sum[32];   // borrow out

    assign sll_res = alu_src1 << alu_src2[4:0];
    assign srl_res = alu_src1 >> alu_src2[4:0];
    assign sra_res = $signed(alu_src1) >>> alu_src2[4:0];

    assign alu_result = ({32{alu_op[ex_pkg::op_add] | alu_op[ex_pkg::op_sub]}} & adder_sum[31:0])
                      | ({32{alu_op[ex_pkg::op_slt]}}  & {31'd0, slt_res})
                      | ({32{alu_op[ex_pkg::op_sltu]}} & {31'd0, sltu_res})
                      | ({32{alu_op[ex_pkg::op_and]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[ex_pkg::op_nor]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[ex_pkg::op_or]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[ex_pkg::op_xor]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[ex_pkg::op_sll]}}  & sll_res)
                      | ({32{alu_op[ex_pkg::op_srl]}}  & srl_res)
                      | ({32{alu_op[ex_pkg::op_sra]}}  & sra_res)
                      | ({32{alu_op[ex_pkg::op_lui]}}  & alu_src2);

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    flush,
    input  wire                    ds_valid,
    input  wire ex_pkg::word_t     ds_pc,
    input  wire ex_pkg::word_t     ds_src1,
    input  wire ex_pkg::word_t     ds_src2,
    input  wire ex_pkg::word_t     ds_rkd,
    input  wire ex_pkg::alu_op_t   ds_alu_op,
    input  wire ex_pkg::md_op_t    ds_md_op,
    input  wire ex_pkg::mem_op_t   ds_mem_op,
    input  wire ex_pkg::cnt_op_t   ds_cnt_op,
    input  wire                    ds_rf_we,
    input  wire ex_pkg::reg_addr_t ds_rf_waddr,
    input  wire ex_pkg::exc_in_t   ds_exc,
    output logic                   es_allowin,
    input  wire                    ms_allowin,
    output logic                   es_to_ms_valid,
    output ex_pkg::word_t          es_pc,
    output ex_pkg::word_t          es_result,
    output logic                   es_rf_we,
    output ex_pkg::reg_addr_t      es_rf_waddr,
    output logic                   es_res_from_mem,
    output logic                   es_mem_req,
    output ex_pkg::exc_t           es_exc,
    output ex_pkg::alu_op_t        alu_op,
    output ex_pkg::word_t          alu_src1,
    output ex_pkg::word_t          alu_src2,
    input  wire ex_pkg::word_t     alu_result,
    output logic                   div_start,
    output logic                   div_signed,
    output ex_pkg::word_t          div_dividend,
    output ex_pkg::word_t          div_divisor,
    input  wire                    div_done,
    input  wire ex_pkg::word_t     div_quot,
    input  wire ex_pkg::word_t     div_rem,
    output ex_pkg::mem_op_t        st_mem_op,
    output ex_pkg::word_t          st_rkd,
    input  wire                    ale,
    input  wire                    mem_access,
    output logic                   data_sram_req,
    output logic                   data_sram_wr,
    output ex_pkg::word_t          data_sram_addr,
    input  wire                    data_sram_addr_ok
);

    logic                es_valid;
    logic                accept;
    logic                ready_go;
    logic                mem_go;
    logic                is_div;
    logic                ds_is_div;
    logic                div_done_q;
    ex_pkg::md_op_t      md_op_q;
    ex_pkg::cnt_op_t     cnt_op_q;
    logic                rf_we_q;
    ex_pkg::exc_in_t     exc_q;
    ex_pkg::stable_cnt_t stable_cnt;
    logic [63:0]         prod_u;
    logic signed [63:0]  prod_s;
    ex_pkg::word_t       quot_fix;
    ex_pkg::word_t       md_result;

    assign accept = ds_valid & es_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            es_pc <= ds_pc;
            alu_src1 <= ds_src1;
            alu_src2 <= ds_src2;
            st_rkd <= ds_rkd;
            alu_op <= ds_alu_op;
            md_op_q <= ds_md_op;
            st_mem_op <= ds_mem_op;
            cnt_op_q <= ds_cnt_op;
            rf_we_q <= ds_rf_we;
            es_rf_waddr <= ds_rf_waddr;
            exc_q <= ds_exc;
        end
    end

    assign prod_u = alu_src1 * alu_src2;
    assign prod_s = $signed(alu_src1) * $signed(alu_src2);

    assign is_div = md_op_q[ex_pkg::md_div_w] | md_op_q[ex_pkg::md_mod_w]
                  | md_op_q[ex_pkg::md_div_wu] | md_op_q[ex_pkg::md_mod_wu];
    assign ds_is_div = ds_md_op[ex_pkg::md_div_w] | ds_md_op[ex_pkg::md_mod_w]
                     | ds_md_op[ex_pkg::md_div_wu] | ds_md_op[ex_pkg::md_mod_wu];

    // one start per divide, in the cycle after acceptance
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_start <= 1'b0;
        end else begin
            div_start <= accept & ds_is_div & ~flush;
        end
    end

    // a done left over from a flushed divide can coincide with the new start
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_done_q <= 1'b0;
        end else if (accept) begin
            div_done_q <= 1'b0;
        end else if (div_done && es_valid && !div_start) begin
            div_done_q <= 1'b1;
        end
    end

    assign div_signed = md_op_q[ex_pkg::md_div_w] | md_op_q[ex_pkg::md_mod_w];
    assign div_dividend = alu_src1;
    assign div_divisor = alu_src2;

    assign quot_fix = (alu_src2 == '0) ? '1 : div_quot;   // divide by zero

    assign md_result = ({32{md_op_q[ex_pkg::md_mul_w]}}   & prod_s[31:0])
                     | ({32{md_op_q[ex_pkg::md_mulh_w]}}  & prod_s[63:32])
                     | ({32{md_op_q[ex_pkg::md_mulh_wu]}} & prod_u[63:32])
                     | ({32{md_op_q[ex_pkg::md_div_w] | md_op_q[ex_pkg::md_div_wu]}} & quot_fix)
                     | ({32{md_op_q[ex_pkg::md_mod_w] | md_op_q[ex_pkg::md_mod_wu]}} & div_rem);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    always_comb begin
        if (cnt_op_q[ex_pkg::cnt_vl]) begin
            es_result = stable_cnt[31:0];
        end else if (cnt_op_q[ex_pkg::cnt_vh]) begin
            es_result = stable_cnt[63:32];
        end else if (|md_op_q) begin
            es_result = md_result;
        end else begin
            es_result = alu_result;
        end
    end

    assign es_exc = {ale, exc_q};
    assign mem_go = mem_access & ~(|es_exc) & ~flush;

    // accepted request leaves the stage in the same cycle
    assign data_sram_req = es_valid & mem_go & ms_allowin;
    assign data_sram_wr = data_sram_req & (st_mem_op[ex_pkg::mem_st_w]
                        | st_mem_op[ex_pkg::mem_st_h] | st_mem_op[ex_pkg::mem_st_b]);
    assign data_sram_addr = {alu_result[31:2], 2'b00};

    assign ready_go = mem_go ? (data_sram_req & data_sram_addr_ok) :
                      is_div ? div_done_q :
                               1'b1;

    assign es_allowin = ~es_valid | (ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid & ready_go & ~flush;

    assign es_rf_we = es_valid & rf_we_q;
    assign es_res_from_mem = es_valid & (|st_mem_op[ex_pkg::mem_ld_bu:ex_pkg::mem_ld_w]);
    assign es_mem_req = es_valid & mem_go;

endmodule

`default_nettype wire

// File: design/ex_top.sv
`default_nettype none

module ex_top #(
    parameter int DIV_W = 32
) (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    flush,
    input  wire                    ds_valid,
    input  wire ex_pkg::word_t     ds_pc,
    input  wire ex_pkg::word_t     ds_src1,
    input  wire ex_pkg::word_t     ds_src2,
    input  wire ex_pkg::word_t     ds_rkd,
    input  wire ex_pkg::alu_op_t   ds_alu_op,
    input  wire ex_pkg::md_op_t    ds_md_op,
    input  wire ex_pkg::mem_op_t   ds_mem_op,
    input  wire ex_pkg::cnt_op_t   ds_cnt_op,
    input  wire                    ds_rf_we,
    input  wire ex_pkg::reg_addr_t ds_rf_waddr,
    input  wire ex_pkg::exc_in_t   ds_exc,
    output logic                   es_allowin,
    input  wire                    ms_allowin,
    output logic                   es_to_ms_valid,
    output ex_pkg::word_t          es_pc,
    output ex_pkg::word_t          es_result,
    output logic                   es_rf_we,
    output ex_pkg::reg_addr_t      es_rf_waddr,
    output logic                   es_res_from_mem,
    output logic                   es_mem_req,
    output ex_pkg::exc_t           es_exc,
    output logic                   data_sram_req,
    output logic                   data_sram_wr,
    output logic [1:0]             data_sram_size,
    output ex_pkg::word_t          data_sram_addr,
    output logic [3:0]             data_sram_wstrb,
    output ex_pkg::word_t          data_sram_wdata,
    input  wire                    data_sram_addr_ok
);

    ex_pkg::alu_op_t alu_op;
    ex_pkg::word_t   alu_src1;
    ex_pkg::word_t   alu_src2;
    ex_pkg::word_t   alu_result;
    logic            div_start;
    logic            div_signed;
    ex_pkg::word_t   div_dividend;
    ex_pkg::word_t   div_divisor;
    logic            div_done;
    ex_pkg::word_t   div_quot;
    ex_pkg::word_t   div_rem;
    ex_pkg::mem_op_t st_mem_op;
    ex_pkg::word_t   st_rkd;
    logic            ale;
    logic            mem_access;

    // stage and alu ports share their names with the nets here
    ex_stage u_ex_stage (.*);

    alu u_alu (.*);

    divider #(
        .DIV_W(DIV_W)
    ) u_divider (
        .clk      (clk),
        .resetn   (resetn),
        .start    (div_start),
        .is_signed(div_signed),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .done     (div_done),
        .quot     (div_quot),
        .rem      (div_rem)
    );

    store_align u_store_align (
        .mem_op    (st_mem_op),
        .addr      (alu_result),
        .rkd       (st_rkd),
        .ale       (ale),
        .mem_access(mem_access),
        .wstrb     (data_sram_wstrb),
        .wdata     (data_sram_wdata),
        .size      (data_sram_size)
    );

endmodule

`default_nettype wire

// File: design/store_align.sv
`default_nettype none

module store_align (
    input  wire ex_pkg::mem_op_t mem_op,
    input  wire ex_pkg::word_t   addr,
    input  wire ex_pkg::word_t   rkd,
    output logic                 ale,
    output logic                 mem_access,
    output logic [3:0]           wstrb,
    output ex_pkg::word_t        wdata,
    output logic [1:0]           size
);

    logic acc_word;
    logic acc_half;
    logic st_w;
    logic st_h;
    logic st_b;

    assign st_w = mem_op[ex_pkg::mem_st_w];
    assign st_h = mem_op[ex_pkg::mem_st_h];
    assign st_b = mem_op[ex_pkg::mem_st_b];

    assign acc_word = mem_op[ex_pkg::mem_ld_w] | st_w;
    assign acc_half = mem_op[ex_pkg::mem_ld_h] | mem_op[ex_pkg::mem_ld_hu] | st_h;

    assign ale = (acc_word & (|addr[1:0])) | (acc_half & addr[0]);
    assign mem_access = |mem_op;

    assign wstrb = ({4{st_b}} & (4'b0001 << addr[1:0]))
                 | ({4{st_h}} & (addr[1] ? 4'b1100 : 4'b0011))
                 | ({4{st_w}} & 4'b1111);

    // replicate into every lane, strobes pick the live bytes
    assign wdata = ({32{st_b}} & {4{rkd[7:0]}})
                 | ({32{st_h}} & {2{rkd[15:0]}})
                 | ({32{st_w}} & rkd);

    // byte loads need no decode here, they fall to size 0
    assign size = acc_word ? 2'd2 :
                  acc_half ? 2'd1 :
                             2'd0;

endmodule

`default_nettype wire

// File: divider/divider.sv
`default_nettype none

module divider #(
    parameter int DIV_W = 32
) (
    input  wire                clk,
    input  wire                resetn,
    input  wire                start,
    input  wire                is_signed,
    input  wire ex_pkg::word_t dividend,
    input  wire ex_pkg::word_t divisor,
    output logic               done,
    output ex_pkg::word_t      quot,
    output ex_pkg::word_t      rem
);

    localparam int cnt_w = $clog2(DIV_W);

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_finish
    } div_state_e;

    div_state_e       state;
    logic [cnt_w-1:0] step;
    logic [DIV_W-1:0] q_reg;    // dividend bits out, quotient bits in
    logic [DIV_W-1:0] r_reg;
    logic [DIV_W-1:0] d_reg;
    logic             neg_q;
    logic             neg_r;
    ex_pkg::word_t    abs_dividend;
    ex_pkg::word_t    abs_divisor;
    logic [DIV_W:0]   shifted;
    logic [DIV_W+1:0] diff;

    assign abs_dividend = (is_signed && dividend[31]) ? -dividend : dividend;
    assign abs_divisor  = (is_signed && divisor[31]) ? -divisor : divisor;

    assign shifted = {r_reg, q_reg[DIV_W-1]};
    assign diff = {1'b0, shifted} - {2'b00, d_reg};

    // a new start always restarts, even mid run
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= div_idle;
            step <= '0;
        end else if (start) begin
            state <= div_run;
            step <= '0;
        end else begin
            case (state)
                div_run: begin
                    step <= step + 1'b1;
                    if (step == cnt_w'(DIV_W - 1)) begin
                        state <= div_finish;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_reg <= abs_dividend;
            r_reg <= '0;
            d_reg <= abs_divisor;
            neg_q <= is_signed & (dividend[31] ^ divisor[31]);
            neg_r <= is_signed & dividend[31];
        end else if (state == div_run) begin
            q_reg <= {q_reg[DIV_W-2:0], ~diff[DIV_W+1]};
            r_reg <= diff[DIV_W+1] ? shifted[DIV_W-1:0] : diff[DIV_W-1:0];  // restore on borrow
        end
    end

    assign done = (state == div_finish);

    // remainder follows the dividend sign
    assign quot = neg_q ? -q_reg : q_reg;
    assign rem  = neg_r ? -r_reg : r_reg;

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
common/ex_pkg.sv
design/alu.sv
divider/divider.sv
design/store_align.sv
design/ex_stage.sv
design/ex_top.sv
tests/tb_ex_top.sv

// File: tests/tb_ex_tasks.svh
`ifndef tb_ex_tasks_svh
`define tb_ex_tasks_svh

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("Mismatch %s: expected %h, actual %h", name, exp, got);
    end
endtask

task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error: %s", msg);
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    $display("%-18s done, %0d errors", name, errors - errs_before);
endtask

// holds ds_valid until the stage takes the instruction
task automatic issue_instr(input ex_pkg::word_t src1, input ex_pkg::word_t src2,
                           input ex_pkg::word_t rkd, input int kind, input int op,
                           input ex_pkg::exc_in_t exc);
    sent++;
    @(posedge clk);
    exp_waddr = 5'(sent % 31 + 1);
    exp_pc = 32'h1c00_0000 + 4 * sent;
    ds_valid <= 1'b1;
    ds_pc <= exp_pc;
    ds_src1 <= src1;
    ds_src2 <= src2;
    ds_rkd <= rkd;
    ds_alu_op <= (kind == k_alu) ? 12'd1 << op :
                 (kind == k_mem) ? 12'd1 << ex_pkg::op_add : 12'd0;   // address add
    ds_md_op <= (kind == k_md) ? 7'd1 << op : 7'd0;
    ds_mem_op <= (kind == k_mem) ? 8'd1 << op : 8'd0;
    ds_cnt_op <= (kind == k_cnt) ? 2'd1 << op : 2'd0;
    ds_rf_we <= 1'b1;
    ds_rf_waddr <= exp_waddr;
    ds_exc <= exc;
    @(negedge clk);
    while (!es_allowin) @(negedge clk);
    @(posedge clk);
    ds_valid <= 1'b0;
endtask

task automatic wait_result();
    @(negedge clk);
    while (!es_to_ms_valid) @(negedge clk);
endtask

task automatic counter_reads();
    int            errs;
    ex_pkg::word_t first;
    errs = errors;
    issue_instr('0, '0, '0, k_cnt, ex_pkg::cnt_vh, '0);
    wait_result();
    check_value("rdcntvh", 0, es_result);
    issue_instr('0, '0, '0, k_cnt, ex_pkg::cnt_vl, '0);
    wait_result();
    first = es_result;
    repeat (10) @(posedge clk);
    issue_instr('0, '0, '0, k_cnt, ex_pkg::cnt_vl, '0);
    wait_result();
    check_true(es_result > first, "second rdcntvl.w read did not increase");
    finish_test("counter", errs);
endtask

task automatic alu_ops();
    int            errs;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    errs = errors;
    for (int i = 0; i < 12; i++) begin
        a = $random(seed);
        b = $random(seed);
        issue_instr(a, b, '0, k_alu, i, '0);
        wait_result();
        check_value("alu", alu_model(i, a, b), es_result);
        check_value("alu pc", exp_pc, es_pc);
        check_value("alu rf", {1'b1, exp_waddr, 2'b00},
                    {es_rf_we, es_rf_waddr, es_res_from_mem, es_mem_req});
    end
    finish_test("alu", errs);
endtask

task automatic mul_ops();
    int            errs;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    errs = errors;
    for (int i = ex_pkg::md_mul_w; i <= ex_pkg::md_mulh_wu; i++) begin
        for (int j = 0; j < 4; j++) begin
            a = (j == 0) ? $random(seed) : (j == 1) ? 32'h8000_0000 : 32'hffff_ffff;
            b = (j == 0) ? $random(seed) : (j == 3) ? 32'h8000_0000 : 32'hffff_ffff;
            issue_instr(a, b, '0, k_md, i, '0);
            wait_result();
            check_value("mul", md_model(i, a, b), es_result);
        end
    end
    finish_test("multiply", errs);
endtask

task automatic div_ops();
    int            errs;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    errs = errors;
    for (int i = ex_pkg::md_div_w; i <= ex_pkg::md_mod_wu; i++) begin
        for (int j = 0; j < 4; j++) begin
            a = (j == 1) ? -32'd100 : (j == 3) ? 32'd77 : $random(seed);
            b = (j == 1) ? 32'd7 : (j == 2) ? 32'd0 : (j == 3) ? -32'd9 : $random(seed);
            issue_instr(a, b, '0, k_md, i, '0);
            wait_result();
            check_value("div", md_model(i, a, b), es_result);
        end
    end
    finish_test("divide", errs);
endtask

task automatic div_backpressure();
    int            errs;
    ex_pkg::word_t a;
    ex_pkg::word_t exp_q;
    errs = errors;
    a = $random(seed);
    exp_q = md_model(ex_pkg::md_div_w, a, 32'd13);
    @(posedge clk);
    ms_allowin <= 1'b0;
    issue_instr(a, 32'd13, '0, k_md, ex_pkg::md_div_w, '0);
    wait_result();
    repeat (5) begin
        @(negedge clk);
        check_value("div hold", {exp_q, 1'b0}, {es_result, es_allowin});
    end
    @(posedge clk);
    ms_allowin <= 1'b1;
    @(negedge clk);
    check_value("div release", {exp_q, 1'b1}, {es_result, es_allowin});
    finish_test("div backpressure", errs);
endtask

task automatic store_ops();
    int            errs;
    ex_pkg::word_t base;
    ex_pkg::word_t d;
    ex_pkg::word_t data;
    logic [3:0]    strb;
    logic [1:0]    size;
    errs = errors;
    for (int i = ex_pkg::mem_st_w; i <= ex_pkg::mem_st_b; i++) begin
        for (int j = 0; j < 4; j++) begin
            if ((i == ex_pkg::mem_st_w && j != 0) || (i == ex_pkg::mem_st_h && j % 2 != 0)) begin
                continue;   // misaligned, covered elsewhere
            end
            base = $random(seed) & 32'hffff_fffc;
            d = $random(seed);
            strb = (i == ex_pkg::mem_st_w) ? 4'hf :
                   (i == ex_pkg::mem_st_h) ? 4'h3 << j : 4'h1 << j;
            data = (i == ex_pkg::mem_st_w) ? d :
                   (i == ex_pkg::mem_st_h) ? {2{d[15:0]}} : {4{d[7:0]}};
            size = (i == ex_pkg::mem_st_w) ? 2'd2 : (i == ex_pkg::mem_st_h) ? 2'd1 : 2'd0;
            issue_instr(base, j, d, k_mem, i, '0);
            wait_result();
            check_value("store addr", base, data_sram_addr);
            check_value("store data", data, data_sram_wdata);
            check_value("store ctrl", {4'b1110, size, strb},
                        {data_sram_req, data_sram_wr, es_mem_req, es_res_from_mem,
                         data_sram_size, data_sram_wstrb});
        end
    end
    finish_test("stores", errs);
endtask

task automatic store_delayed_ack();
    int            errs;
    logic          early;
    ex_pkg::word_t base;
    errs = errors;
    early = 1'b0;
    base = $random(seed) & 32'hffff_fffc;
    @(posedge clk);
    data_sram_addr_ok <= 1'b0;
    issue_instr(base, '0, 32'hcafe_0123, k_mem, ex_pkg::mem_st_w, '0);
    repeat (3) begin
        @(negedge clk);
        early = early | es_to_ms_valid | ~data_sram_req;
    end
    check_true(!early, "store left the stage or dropped its request before acceptance");
    @(posedge clk);
    data_sram_addr_ok <= 1'b1;
    wait_result();
    check_value("delayed store", {base, 32'hcafe_0123}, {data_sram_addr, data_sram_wdata});
    finish_test("store delayed ack", errs);
endtask

task automatic exc_and_flush();
    int            errs;
    logic          seen;
    ex_pkg::word_t base;
    errs = errors;
    seen = 1'b0;
    base = $random(seed) & 32'hffff_fffc;
    issue_instr(base, 32'd1, '0, k_mem, ex_pkg::mem_ld_w, '0);
    wait_result();
    check_value("ld.w ale", 4'b0110,
                {data_sram_req, es_exc[6], es_res_from_mem, es_mem_req});
    issue_instr(base, 32'd3, 32'h55aa, k_mem, ex_pkg::mem_st_h, '0);
    wait_result();
    check_value("st.h ale", 2'b01, {data_sram_req, es_exc[6]});
    issue_instr(base, '0, 32'h1234, k_mem, ex_pkg::mem_st_w, 6'b000100);
    wait_result();
    check_value("exc pass", {1'b0, 7'b0000100}, {data_sram_req, es_exc});
    issue_instr($random(seed), 32'd5, '0, k_md, ex_pkg::md_div_w, '0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    repeat (40) begin
        @(negedge clk);
        seen = seen | es_to_ms_valid;
    end
    check_true(!seen, "flushed divide still reached the memory stage");
    finish_test("exceptions, flush", errs);
endtask

`endif

// File: tests/tb_ex_top.sv
`default_nettype none

module tb_ex_top;

    localparam int reset_cycles = 4;
    localparam int cycles_per_instr = 60;
    // instruction kinds for issue_instr
    localparam int k_alu = 0;
    localparam int k_md  = 1;
    localparam int k_mem = 2;
    localparam int k_cnt = 3;

    logic                clk;
    logic                resetn;
    logic                flush;
    logic                ds_valid;
    ex_pkg::word_t       ds_pc;
    ex_pkg::word_t       ds_src1;
    ex_pkg::word_t       ds_src2;
    ex_pkg::word_t       ds_rkd;
    ex_pkg::alu_op_t     ds_alu_op;
    ex_pkg::md_op_t      ds_md_op;
    ex_pkg::mem_op_t     ds_mem_op;
    ex_pkg::cnt_op_t     ds_cnt_op;
    logic                ds_rf_we;
    ex_pkg::reg_addr_t   ds_rf_waddr;
    ex_pkg::exc_in_t     ds_exc;
    logic                es_allowin;
    logic                ms_allowin;
    logic                es_to_ms_valid;
    ex_pkg::word_t       es_pc;
    ex_pkg::word_t       es_result;
    logic                es_rf_we;
    ex_pkg::reg_addr_t   es_rf_waddr;
    logic                es_res_from_mem;
    logic                es_mem_req;
    ex_pkg::exc_t        es_exc;
    logic                data_sram_req;
    logic                data_sram_wr;
    logic [1:0]          data_sram_size;
    ex_pkg::word_t       data_sram_addr;
    logic [3:0]          data_sram_wstrb;
    ex_pkg::word_t       data_sram_wdata;
    logic                data_sram_addr_ok;

    integer              seed;
    int                  checks;
    int                  errors;
    int                  sent = 0;
    int                  cycles = 0;
    ex_pkg::reg_addr_t   exp_waddr;
    ex_pkg::word_t       exp_pc;

    ex_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // budget grows with every instruction handed to the stage
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycles_per_instr * sent + reset_cycles) begin
            $display("timeout after %0d cycles, stage stopped responding", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic ex_pkg::word_t alu_model(input int op, input ex_pkg::word_t a,
                                                input ex_pkg::word_t b);
        case (op)
            ex_pkg::op_add:  return a + b;
            ex_pkg::op_sub:  return a - b;
            ex_pkg::op_slt:  return {31'd0, $signed(a) < $signed(b)};
            ex_pkg::op_sltu: return {31'd0, a < b};
            ex_pkg::op_and:  return a & b;
            ex_pkg::op_nor:  return ~(a | b);
            ex_pkg::op_or:   return a | b;
            ex_pkg::op_xor:  return a ^ b;
            ex_pkg::op_sll:  return a << b[4:0];
            ex_pkg::op_srl:  return a >> b[4:0];
            ex_pkg::op_sra:  return $signed(a) >>> b[4:0];
            default:         return b;   // lui
        endcase
    endfunction

    function automatic ex_pkg::word_t md_model(input int op, input ex_pkg::word_t a,
                                               input ex_pkg::word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] qs;
        logic signed [31:0] rs;
        logic signed [63:0] ps;
        logic [63:0]        pu;
        sa = a;
        sb = b;
        ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        pu = {32'd0, a} * {32'd0, b};
        if (b != 0) begin
            qs = sa / sb;
            rs = sa % sb;
        end else begin
            qs = '1;
            rs = sa;
        end
        case (op)
            ex_pkg::md_mul_w:   return ps[31:0];
            ex_pkg::md_mulh_w:  return ps[63:32];
            ex_pkg::md_mulh_wu: return pu[63:32];
            ex_pkg::md_div_w:   return qs;
            ex_pkg::md_mod_w:   return rs;
            ex_pkg::md_div_wu:  return (b != 0) ? a / b : '1;
            default:            return (b != 0) ? a % b : a;
        endcase
    endfunction

    `include "tb_ex_tasks.svh"

    initial begin
        seed = 83215;
        checks = 0;
        errors = 0;
        resetn = 1'b0;
        flush = 1'b0;
        ds_valid = 1'b0;
        ds_pc = '0;
        ds_src1 = '0;
        ds_src2 = '0;
        ds_rkd = '0;
        ds_alu_op = '0;
        ds_md_op = '0;
        ds_mem_op = '0;
        ds_cnt_op = '0;
        ds_rf_we = 1'b0;
        ds_rf_waddr = '0;
        ds_exc = '0;
        ms_allowin = 1'b1;
        data_sram_addr_ok = 1'b1;
        exp_waddr = '0;
        exp_pc = '0;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
        counter_reads();
        alu_ops();
        mul_ops();
        div_ops();
        div_backpressure();
        store_ops();
        store_delayed_ack();
        exc_and_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
